// File: all.f
+incdir+.
rename_pkg.sv
arch_map_table.sv
free_list.sv
maptable.sv
rename_top.sv
tb_rename.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - rename_pkg.sv
  - arch_map_table.sv
  - free_list.sv
  - maptable.sv
  - rename_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rename.sv

// File: tb_rename_model.svh
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

// Reference state of the rename stage. It advances one clock edge at a time.
logic [rename_pkg::TAG_W-1:0]     mdl_map [rename_pkg::ARCH_REGS];
logic                             mdl_rdy [rename_pkg::ARCH_REGS];
logic [rename_pkg::TAG_W-1:0]     mdl_amt [rename_pkg::ARCH_REGS];
logic [rename_pkg::PHYS_REGS-1:0] mdl_free;

function automatic void model_reset();
    for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
        mdl_map[r] = rename_pkg::TAG_W'(r);
        mdl_rdy[r] = 1'b1;
        mdl_amt[r] = rename_pkg::TAG_W'(r);
    end
    for (int t = 0; t < rename_pkg::PHYS_REGS; t++) begin
        mdl_free[t] = (t >= rename_pkg::ARCH_REGS);
    end
endfunction

function automatic logic renames(input rename_pkg::dp_req_t d);
    return d.valid && d.wr_en && (d.rd != '0);
endfunction

function automatic logic on_cdb(input rename_pkg::cdb_t [rename_pkg::CDB_NUM-1:0] cdb,
                                input logic [rename_pkg::TAG_W-1:0] tag);
    for (int c = 0; c < rename_pkg::CDB_NUM; c++) begin
        if (cdb[c].valid && cdb[c].tag == tag) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// One register as seen by slot s, packed as {tag, ready}.
function automatic logic [rename_pkg::TAG_W:0] lookup(
    input int                                         s,
    input logic [rename_pkg::AREG_W-1:0]              areg,
    input rename_pkg::dp_req_t [rename_pkg::DP_NUM-1:0]  dp,
    input rename_pkg::alloc_t  [rename_pkg::DP_NUM-1:0]  alc,
    input rename_pkg::cdb_t    [rename_pkg::CDB_NUM-1:0] cdb
);
    logic [rename_pkg::TAG_W-1:0] tag;
    if (areg == '0) begin
        return {{rename_pkg::TAG_W{1'b0}}, 1'b1};
    end
    if (s == 1 && alc[0].valid && dp[0].rd == areg) begin
        return {alc[0].tag, 1'b0};
    end
    tag = mdl_map[areg];
    return {tag, mdl_rdy[areg] | on_cdb(cdb, tag)};
endfunction

function automatic void model_expect(
    input  rename_pkg::dp_req_t     [rename_pkg::DP_NUM-1:0]  dp,
    input  rename_pkg::cdb_t        [rename_pkg::CDB_NUM-1:0] cdb,
    input  logic                                              rb,
    output logic                                              ready,
    output rename_pkg::alloc_t      [rename_pkg::DP_NUM-1:0]  alc,
    output rename_pkg::rename_rsp_t [rename_pkg::DP_NUM-1:0]  rsp
);
    int                          free_tags[$];
    int                          need;
    logic [rename_pkg::TAG_W:0]  pick;
    need = 0;
    for (int t = 1; t < rename_pkg::PHYS_REGS; t++) begin
        if (mdl_free[t]) begin
            free_tags.push_back(t);
        end
    end
    for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
        need += renames(dp[s]);
    end
    ready = !rb && (need <= free_tags.size());
    alc = '0;
    for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
        if (ready && renames(dp[s])) begin
            alc[s].valid = 1'b1;
            alc[s].tag   = rename_pkg::TAG_W'(free_tags.pop_front());
        end
    end
    for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
        {rsp[s].tag1, rsp[s].tag1_ready} = lookup(s, dp[s].rs1, dp, alc, cdb);
        {rsp[s].tag2, rsp[s].tag2_ready} = lookup(s, dp[s].rs2, dp, alc, cdb);
        pick = lookup(s, dp[s].rd, dp, alc, cdb);
        rsp[s].tag_old = pick[rename_pkg::TAG_W:1];
        rsp[s].new_tag = alc[s].tag;
    end
endfunction

function automatic void model_commit(
    input rename_pkg::dp_req_t [rename_pkg::DP_NUM-1:0]  dp,
    input rename_pkg::alloc_t  [rename_pkg::DP_NUM-1:0]  alc,
    input rename_pkg::cdb_t    [rename_pkg::CDB_NUM-1:0] cdb,
    input rename_pkg::retire_t [rename_pkg::DP_NUM-1:0]  ret,
    input logic                                          rb
);
    logic [rename_pkg::PHYS_REGS-1:0] held;
    held = '0;
    if (rb) begin
        for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
            mdl_map[r] = mdl_amt[r];
            mdl_rdy[r] = 1'b1;
            held[mdl_amt[r]] = 1'b1;
        end
        mdl_free    = ~held;
        mdl_free[0] = 1'b0;
    end else begin
        for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
            if (on_cdb(cdb, mdl_map[r])) begin
                mdl_rdy[r] = 1'b1;
            end
        end
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            if (alc[s].valid) begin
                mdl_map[dp[s].rd]   = alc[s].tag;
                mdl_rdy[dp[s].rd]   = 1'b0;
                mdl_free[alc[s].tag] = 1'b0;
            end
        end
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            if (ret[s].valid && ret[s].rd != '0 && ret[s].tag_old != '0) begin
                mdl_free[ret[s].tag_old] = 1'b1;
            end
        end
    end
    // The committed map follows retire even in a rollback cycle.
    for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
        if (ret[s].valid && ret[s].rd != '0) begin
            mdl_amt[ret[s].rd] = ret[s].tag;
        end
    end
endfunction

`endif

// File: tb_rename.sv
`timescale 1ns/10ps

module tb_rename;

    localparam logic [1:0] MODE_ONCE = 2'd0;
    localparam logic [1:0] MODE_FILL = 2'd1;
    localparam logic [1:0] MODE_HOLD = 2'd2;
    localparam int WAIT_LIMIT = 40;
    localparam rename_pkg::dp_req_t NO_SLOT = '0;
    localparam rename_pkg::cdb_t NO_CDB = '0;

    // FILL repeats a group until dispatch stalls, HOLD keeps a group until it is accepted.
    typedef struct packed {
        logic [1:0]                                    mode;
        logic                                          rnd;
        rename_pkg::dp_req_t [rename_pkg::DP_NUM-1:0]  dp;
        rename_pkg::cdb_t    [rename_pkg::CDB_NUM-1:0] cdb;
        logic [1:0]                                    ret_n;
        logic                                          rb;
        logic [rename_pkg::TAG_W-1:0]                  exp_new0;
    } row_t;

    logic                                             clk_i = 1'b0;
    logic                                             rst_i;
    logic                                             rollback_i;
    rename_pkg::dp_req_t     [rename_pkg::DP_NUM-1:0]  dispatch_i;
    rename_pkg::cdb_t        [rename_pkg::CDB_NUM-1:0] cdb_i;
    rename_pkg::retire_t     [rename_pkg::DP_NUM-1:0]  retire_i;
    logic                                             dispatch_ready_o;
    rename_pkg::rename_rsp_t [rename_pkg::DP_NUM-1:0]  rename_o;

    row_t                rows[$];
    rename_pkg::retire_t rob_q[$];
    int                  err_cnt = 0;

    `include "tb_rename_model.svh"

    rename_top rename_top_inst (.*);

    always #10 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic rename_pkg::dp_req_t slot(input logic wr, input int rd,
                                                 input int rs1, input int rs2);
        rename_pkg::dp_req_t d;
        d.valid = 1'b1;
        d.wr_en = wr;
        d.rd    = rename_pkg::AREG_W'(rd);
        d.rs1   = rename_pkg::AREG_W'(rs1);
        d.rs2   = rename_pkg::AREG_W'(rs2);
        return d;
    endfunction

    function automatic rename_pkg::cdb_t bcast(input int tag);
        return {1'b1, rename_pkg::TAG_W'(tag)};
    endfunction

    task automatic add_row(input logic [1:0] mode, input logic rnd,
                           input rename_pkg::dp_req_t s0, input rename_pkg::dp_req_t s1,
                           input rename_pkg::cdb_t c0, input rename_pkg::cdb_t c1,
                           input int ret_n, input logic rb, input int exp_new0);
        row_t r;
        r.mode     = mode;
        r.rnd      = rnd;
        r.dp       = {s1, s0};
        r.cdb      = {c1, c0};
        r.ret_n    = 2'(ret_n);
        r.rb       = rb;
        r.exp_new0 = rename_pkg::TAG_W'(exp_new0);
        rows.push_back(r);
    endtask

    // Last column is the new tag of slot 0 in the first accepted cycle of the row.
    task automatic build_table();
        add_row(MODE_ONCE, 0, slot(1, 1, 2, 3), slot(1, 4, 1, 0), NO_CDB, NO_CDB, 0, 0, 32);
        add_row(MODE_ONCE, 0, slot(1, 1, 1, 4), slot(1, 1, 1, 5), NO_CDB, NO_CDB, 0, 0, 34);
        add_row(MODE_ONCE, 0, slot(1, 6, 4, 1), NO_SLOT, bcast(33), bcast(35), 0, 0, 36);
        add_row(MODE_ONCE, 0, slot(0, 7, 4, 1), slot(1, 7, 6, 4), NO_CDB, NO_CDB, 0, 0, 0);
        add_row(MODE_ONCE, 0, slot(1, 0, 0, 0), slot(1, 8, 0, 7), NO_CDB, NO_CDB, 0, 0, 0);
        add_row(MODE_ONCE, 1, slot(1, 9, 0, 0), slot(1, 10, 0, 0), NO_CDB, NO_CDB, 0, 0, 39);
        add_row(MODE_ONCE, 1, slot(1, 2, 0, 0), slot(1, 3, 0, 0), NO_CDB, NO_CDB, 0, 0, 41);
        add_row(MODE_ONCE, 0, NO_SLOT, NO_SLOT, NO_CDB, NO_CDB, 2, 0, 0);
        add_row(MODE_FILL, 1, slot(1, 11, 0, 0), slot(1, 12, 0, 0), NO_CDB, NO_CDB, 0, 0, 1);
        add_row(MODE_ONCE, 0, slot(1, 15, 11, 12), NO_SLOT, NO_CDB, NO_CDB, 0, 0, 63);
        add_row(MODE_ONCE, 0, slot(0, 3, 15, 2), NO_SLOT, NO_CDB, NO_CDB, 0, 0, 0);
        add_row(MODE_HOLD, 0, slot(1, 13, 15, 1), slot(1, 14, 13, 0), NO_CDB, NO_CDB, 2, 0, 32);
        add_row(MODE_ONCE, 0, NO_SLOT, NO_SLOT, bcast(36), bcast(37), 0, 0, 0);
        add_row(MODE_ONCE, 0, NO_SLOT, NO_SLOT, NO_CDB, NO_CDB, 2, 0, 0);
        add_row(MODE_ONCE, 0, slot(1, 6, 6, 7), slot(1, 1, 6, 3), NO_CDB, NO_CDB, 0, 0, 6);
        add_row(MODE_ONCE, 0, NO_SLOT, NO_SLOT, NO_CDB, NO_CDB, 1, 0, 0);
        add_row(MODE_ONCE, 0, slot(1, 5, 1, 2), NO_SLOT, NO_CDB, NO_CDB, 0, 1, 0);
        add_row(MODE_ONCE, 0, slot(1, 20, 1, 6), slot(1, 21, 4, 8), NO_CDB, NO_CDB, 0, 0, 1);
        add_row(MODE_ONCE, 1, slot(1, 22, 0, 0), slot(1, 23, 0, 0), NO_CDB, NO_CDB, 0, 0, 6);
        add_row(MODE_ONCE, 0, slot(0, 0, 20, 21), NO_SLOT, bcast(1), bcast(4), 0, 0, 0);
        add_row(MODE_ONCE, 0, NO_SLOT, NO_SLOT, NO_CDB, NO_CDB, 2, 0, 0);
        add_row(MODE_ONCE, 0, slot(1, 0, 0, 20), slot(1, 24, 0, 0), NO_CDB, NO_CDB, 0, 0, 0);
        add_row(MODE_ONCE, 1, slot(1, 25, 0, 0), slot(1, 25, 0, 0), NO_CDB, NO_CDB, 0, 0, 20);
        add_row(MODE_ONCE, 0, slot(1, 26, 25, 0), slot(1, 27, 26, 25), NO_CDB, NO_CDB, 0, 0, 32);
    endtask

    // The testbench plays the ROB. Retires are taken oldest first from rob_q.
    task automatic drive_row(input row_t r, input int cyc);
        rename_pkg::dp_req_t [rename_pkg::DP_NUM-1:0] dp;
        rename_pkg::retire_t [rename_pkg::DP_NUM-1:0] ret;
        dp  = r.dp;
        ret = '0;
        if (r.mode == MODE_HOLD && cyc > 0) begin
            dp = dispatch_i;
        end else if (r.rnd) begin
            for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
                dp[s].rs1 = rename_pkg::AREG_W'($urandom % rename_pkg::ARCH_REGS);
                dp[s].rs2 = rename_pkg::AREG_W'($urandom % rename_pkg::ARCH_REGS);
            end
        end
        for (int s = 0; s < r.ret_n && cyc == 0 && rob_q.size() > 0; s++) begin
            ret[s] = rob_q.pop_front();
        end
        @(posedge clk_i);
        dispatch_i <= dp;
        cdb_i      <= (cyc == 0) ? r.cdb : '0;
        retire_i   <= ret;
        rollback_i <= (cyc == 0) ? r.rb : 1'b0;
    endtask

    task automatic sample_and_check(input int idx, input row_t r, input logic first_acc,
                                    output logic acc);
        logic                                             ready;
        rename_pkg::alloc_t      [rename_pkg::DP_NUM-1:0] alc;
        rename_pkg::rename_rsp_t [rename_pkg::DP_NUM-1:0] rsp;
        rename_pkg::retire_t                              ent;
        @(negedge clk_i);
        model_expect(dispatch_i, cdb_i, rollback_i, ready, alc, rsp);
        check_value($sformatf("row %0d dispatch_ready_o", idx), dispatch_ready_o, ready);
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            if (ready && dispatch_i[s].valid) begin
                check_value($sformatf("row %0d slot %0d rename_o", idx, s), rename_o[s], rsp[s]);
            end
            if (alc[s].valid) begin
                ent.valid   = 1'b1;
                ent.rd      = dispatch_i[s].rd;
                ent.tag     = alc[s].tag;
                ent.tag_old = rsp[s].tag_old;
                rob_q.push_back(ent);
            end
        end
        if (ready && first_acc) begin
            check_value($sformatf("row %0d table new_tag", idx), rename_o[0].new_tag, r.exp_new0);
        end
        // A rollback squashes every instruction still in flight.
        if (rollback_i) begin
            rob_q.delete();
        end
        model_commit(dispatch_i, alc, cdb_i, retire_i, rollback_i);
        acc = ready;
    endtask

    initial begin : run_rows
        logic acc;
        logic first_acc;
        logic done;
        int   cyc;
        rst_i      = 1'b1;
        rollback_i = 1'b0;
        dispatch_i = '0;
        cdb_i      = '0;
        retire_i   = '0;
        void'($urandom(48));
        build_table();
        model_reset();
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        foreach (rows[i]) begin
            cyc       = 0;
            first_acc = 1'b1;
            done      = 1'b0;
            while (!done) begin
                drive_row(rows[i], cyc);
                sample_and_check(i, rows[i], first_acc, acc);
                first_acc = first_acc && !acc;
                cyc++;
                done = (rows[i].mode == MODE_ONCE) || ((rows[i].mode == MODE_FILL) ? !acc : acc);
                if (!done && cyc >= WAIT_LIMIT) begin
                    $display("Test failed");
                    $fatal(1, "Timeout: dispatch_ready_o stuck for %0d cycles in row %0d",
                           WAIT_LIMIT, i);
                end
            end
        end
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rename_top.sv
`timescale 1ns/10ps

module rename_top (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  logic                                              rollback_i,
    input  rename_pkg::dp_req_t     [rename_pkg::DP_NUM-1:0]  dispatch_i,
    input  rename_pkg::cdb_t        [rename_pkg::CDB_NUM-1:0] cdb_i,
    input  rename_pkg::retire_t     [rename_pkg::DP_NUM-1:0]  retire_i,
    output logic                                              dispatch_ready_o,
    output rename_pkg::rename_rsp_t [rename_pkg::DP_NUM-1:0]  rename_o
);

    // ****************************************
    // Internal nets
    // ****************************************

    // Allocations double as the map table write enables.
    rename_pkg::alloc_t [rename_pkg::DP_NUM-1:0] alloc;

    // Committed map, the rollback source for both the map table and the free list.
    rename_pkg::amt_vec_t amt_vec;

    // ****************************************
    // Blocks
    // ****************************************

    maptable maptable_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rollback_i (rollback_i),
        .dispatch_i (dispatch_i),
        .alloc_i    (alloc),
        .cdb_i      (cdb_i),
        .amt_i      (amt_vec),
        .rename_o   (rename_o)
    );

    free_list free_list_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .rollback_i       (rollback_i),
        .dispatch_i       (dispatch_i),
        .retire_i         (retire_i),
        .amt_i            (amt_vec),
        .alloc_o          (alloc),
        .dispatch_ready_o (dispatch_ready_o)
    );

    arch_map_table arch_map_table_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .retire_i (retire_i),
        .amt_o    (amt_vec)
    );

endmodule

// File: maptable.sv
`timescale 1ns/10ps

module maptable (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      rollback_i,
    input  rename_pkg::dp_req_t     [rename_pkg::DP_NUM-1:0]  dispatch_i,
    input  rename_pkg::alloc_t      [rename_pkg::DP_NUM-1:0]  alloc_i,
    input  rename_pkg::cdb_t        [rename_pkg::CDB_NUM-1:0] cdb_i,
    input  rename_pkg::amt_vec_t                              amt_i,
    output rename_pkg::rename_rsp_t [rename_pkg::DP_NUM-1:0]  rename_o
);

    logic [rename_pkg::TAG_W-1:0] mt_tag [rename_pkg::ARCH_REGS];
    logic                         mt_rdy [rename_pkg::ARCH_REGS];

    // True when any valid CDB carries the given tag in this cycle.
    function automatic logic cdb_hit(
        input rename_pkg::cdb_t [rename_pkg::CDB_NUM-1:0] cdb,
        input logic [rename_pkg::TAG_W-1:0]                tag
    );
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < rename_pkg::CDB_NUM; c++) begin
            if (cdb[c].valid && cdb[c].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ****************************************
    // Lookup
    // ****************************************

    always_comb begin
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            // Start from the stored mapping with the CDB bypass applied.
            rename_o[s].tag1       = mt_tag[dispatch_i[s].rs1];
            rename_o[s].tag1_ready = mt_rdy[dispatch_i[s].rs1] |
                                     cdb_hit(cdb_i, mt_tag[dispatch_i[s].rs1]);
            rename_o[s].tag2       = mt_tag[dispatch_i[s].rs2];
            rename_o[s].tag2_ready = mt_rdy[dispatch_i[s].rs2] |
                                     cdb_hit(cdb_i, mt_tag[dispatch_i[s].rs2]);
            rename_o[s].tag_old    = mt_tag[dispatch_i[s].rd];
            rename_o[s].new_tag    = alloc_i[s].valid ? alloc_i[s].tag : '0;

            // An older slot in the same group that renames the register wins.
            // Later slots are visited last so the youngest writer is kept.
            for (int p = 0; p < s; p++) begin
                if (alloc_i[p].valid) begin
                    if (dispatch_i[s].rs1 == dispatch_i[p].rd) begin
                        rename_o[s].tag1       = alloc_i[p].tag;
                        rename_o[s].tag1_ready = 1'b0;
                    end
                    if (dispatch_i[s].rs2 == dispatch_i[p].rd) begin
                        rename_o[s].tag2       = alloc_i[p].tag;
                        rename_o[s].tag2_ready = 1'b0;
                    end
                    if (dispatch_i[s].rd == dispatch_i[p].rd) begin
                        rename_o[s].tag_old = alloc_i[p].tag;
                    end
                end
            end

            // Register 0 is hardwired to tag 0 and always ready.
            if (dispatch_i[s].rs1 == '0) begin
                rename_o[s].tag1       = '0;
                rename_o[s].tag1_ready = 1'b1;
            end
            if (dispatch_i[s].rs2 == '0) begin
                rename_o[s].tag2       = '0;
                rename_o[s].tag2_ready = 1'b1;
            end
            if (dispatch_i[s].rd == '0) begin
                rename_o[s].tag_old = '0;
            end
        end
    end

    // ****************************************
    // Table update
    // ****************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                mt_tag[r] <= rename_pkg::TAG_W'(r);
                mt_rdy[r] <= 1'b1;
            end
        end else if (rollback_i) begin
            // Committed state is restored and every committed value is ready.
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                mt_tag[r] <= amt_i[r];
                mt_rdy[r] <= 1'b1;
            end
        end else begin
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                if (cdb_hit(cdb_i, mt_tag[r])) begin
                    mt_rdy[r] <= 1'b1;
                end
            end
            // New mappings come after the wake-up so they stay not ready.
            // Slot order gives the younger slot the final write.
            for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
                if (alloc_i[s].valid) begin
                    mt_tag[dispatch_i[s].rd] <= alloc_i[s].tag;
                    mt_rdy[dispatch_i[s].rd] <= 1'b0;
                end
            end
        end
    end

    // Two renames of one register in a group leave the younger tag in the table.
    property p_same_rd_slot1_wins;
        @(posedge clk_i) disable iff (rst_i)
        (!rollback_i && alloc_i[0].valid && alloc_i[1].valid &&
         dispatch_i[0].rd == dispatch_i[1].rd)
        |=> (mt_tag[$past(dispatch_i[1].rd)] == $past(alloc_i[1].tag));
    endproperty

    a_same_rd_slot1_wins: assert property (p_same_rd_slot1_wins)
        else $error("maptable: slot 1 mapping lost on shared rd");

endmodule

// File: free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic                                            clk_i,
    input  logic                                            rst_i,
    input  logic                                            rollback_i,
    input  rename_pkg::dp_req_t  [rename_pkg::DP_NUM-1:0]   dispatch_i,
    input  rename_pkg::retire_t  [rename_pkg::DP_NUM-1:0]   retire_i,
    input  rename_pkg::amt_vec_t                            amt_i,
    output rename_pkg::alloc_t   [rename_pkg::DP_NUM-1:0]   alloc_o,
    output logic                                            dispatch_ready_o
);

    logic [rename_pkg::PHYS_REGS-1:0] free_q;
    logic [rename_pkg::PHYS_REGS-1:0] second_vec;
    logic [rename_pkg::PHYS_REGS-1:0] alloc_mask;
    logic [rename_pkg::PHYS_REGS-1:0] retire_mask;
    logic [rename_pkg::PHYS_REGS-1:0] in_amt;
    logic [rename_pkg::PHYS_REGS-1:0] rebuild_free;
    logic [rename_pkg::DP_NUM-1:0]    req;
    logic [1:0]                       need_cnt;
    logic [1:0]                       avail_cnt;
    rename_pkg::alloc_t               first_free;
    rename_pkg::alloc_t               second_free;

    // Lowest set bit of the vector, scanned from the top so the lowest index wins.
    function automatic rename_pkg::alloc_t find_lowest(
        input logic [rename_pkg::PHYS_REGS-1:0] vec
    );
        rename_pkg::alloc_t res;
        res = '0;
        for (int i = rename_pkg::PHYS_REGS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                res.valid = 1'b1;
                res.tag   = rename_pkg::TAG_W'(i);
            end
        end
        return res;
    endfunction

    // ****************************************
    // Allocation and acceptance
    // ****************************************

    always_comb begin
        first_free = find_lowest(free_q);
        second_vec = free_q;
        second_vec[first_free.tag] = 1'b0;
        second_free = find_lowest(second_vec);
        avail_cnt = 2'(first_free.valid) + 2'(second_free.valid);
    end

    // A slot renames only when it writes a register other than 0.
    always_comb begin
        need_cnt = '0;
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            req[s]   = dispatch_i[s].valid && dispatch_i[s].wr_en && dispatch_i[s].rd != '0;
            need_cnt = need_cnt + 2'(req[s]);
        end
    end

    assign dispatch_ready_o = !rollback_i && (need_cnt <= avail_cnt);

    always_comb begin
        alloc_o[0].valid = dispatch_ready_o && req[0];
        alloc_o[0].tag   = first_free.tag;
        alloc_o[1].valid = dispatch_ready_o && req[1];
        alloc_o[1].tag   = req[0] ? second_free.tag : first_free.tag;
    end

    // ****************************************
    // Bitmap update
    // ****************************************

    always_comb begin
        alloc_mask  = '0;
        retire_mask = '0;
        for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
            if (alloc_o[s].valid) begin
                alloc_mask[alloc_o[s].tag] = 1'b1;
            end
            if (retire_i[s].valid && retire_i[s].rd != '0 && retire_i[s].tag_old != '0) begin
                retire_mask[retire_i[s].tag_old] = 1'b1;
            end
        end
    end

    // On rollback every tag outside the committed map is free again.
    always_comb begin
        in_amt = '0;
        for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
            in_amt[amt_i[r]] = 1'b1;
        end
        rebuild_free    = ~in_amt;
        rebuild_free[0] = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            free_q <= rename_pkg::FREE_RESET;
        end else if (rollback_i) begin
            free_q <= rebuild_free;
        end else begin
            free_q <= (free_q & ~alloc_mask) | retire_mask;
        end
    end

    // Handed-out tags are never the zero register and always come from the bitmap.
    for (genvar s = 0; s < rename_pkg::DP_NUM; s++) begin : g_alloc_chk
        a_alloc_free: assert property (
            @(posedge clk_i) disable iff (rst_i)
            alloc_o[s].valid |-> (alloc_o[s].tag != '0 && free_q[alloc_o[s].tag])
        ) else $error("free_list: slot %0d allocated a tag that was not free", s);
    end

endmodule

// File: arch_map_table.sv
`timescale 1ns/10ps

module arch_map_table (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  rename_pkg::retire_t [rename_pkg::DP_NUM-1:0]  retire_i,
    output rename_pkg::amt_vec_t                          amt_o
);

    rename_pkg::amt_vec_t amt_q;

    // ****************************************
    // Committed map
    // ****************************************

    // The table only moves forward on retire. A rollback reads it as the
    // recovery point and leaves it untouched.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
                amt_q[r] <= rename_pkg::TAG_W'(r);
            end
        end else begin
            // Slot 1 retires after slot 0, so its write lands last.
            for (int s = 0; s < rename_pkg::DP_NUM; s++) begin
                if (retire_i[s].valid && retire_i[s].rd != '0) begin
                    amt_q[retire_i[s].rd] <= retire_i[s].tag;
                end
            end
        end
    end

    assign amt_o = amt_q;

endmodule

// File: rename_pkg.sv
package rename_pkg;

    // ****************************************
    // Widths and counts
    // ****************************************

    // Dispatch slots per cycle. The retire path uses the same number of slots.
    localparam int DP_NUM = 2;

    // Result buses broadcasting completed tags.
    localparam int CDB_NUM = 2;

    localparam int ARCH_REGS = 32;
    localparam int AREG_W = $clog2(ARCH_REGS);

    localparam int PHYS_REGS = 64;
    localparam int TAG_W = $clog2(PHYS_REGS);

    // Free bitmap after reset. Tags below ARCH_REGS hold the identity map.
    localparam logic [PHYS_REGS-1:0] FREE_RESET = {
        {(PHYS_REGS - ARCH_REGS){1'b1}},
        {ARCH_REGS{1'b0}}
    };

    // ****************************************
    // Interface structs
    // ****************************************

    // One dispatch slot as seen by rename.
    typedef struct packed {
        logic              valid;
        logic              wr_en;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
    } dp_req_t;

    // One physical register handed out by the free list.
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } alloc_t;

    // Rename result for one dispatch slot.
    typedef struct packed {
        logic [TAG_W-1:0] tag1;
        logic             tag1_ready;
        logic [TAG_W-1:0] tag2;
        logic             tag2_ready;
        logic [TAG_W-1:0] new_tag;
        logic [TAG_W-1:0] tag_old;
    } rename_rsp_t;

    // One result broadcast on a CDB.
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } cdb_t;

    // One retiring instruction from the ROB.
    typedef struct packed {
        logic              valid;
        logic [AREG_W-1:0] rd;
        logic [TAG_W-1:0]  tag;
        logic [TAG_W-1:0]  tag_old;
    } retire_t;

    // Committed mapping, one physical tag per architectural register.
    typedef logic [ARCH_REGS-1:0][TAG_W-1:0] amt_vec_t;

endpackage
